//--- hdl/ntt_ctrl_params.svh
/*
 * NTT controller memory map and timing constants.
 * Coefficient, word and BRAM geometry for the load phase,
 * plus decode, execute and butterfly latencies.
 */
`ifndef NTT_CTRL_PARAMS_SVH
`define NTT_CTRL_PARAMS_SVH

// Coefficient and input word geometry
`define NTT_COEFF_W          12   // Bits per coefficient
`define NTT_COEFFS_PER_WORD  16   // Coefficients in one input word
`define NTT_WORD_W           192  // Input word width
`define NTT_PAIRS_PER_WORD   8    // Even/odd pairs per word

// BRAM layout
`define NTT_ADDR_W           5    // 32 entries per BRAM
`define NTT_NUM_BRAM         8    // Also the write enable width
`define NTT_WORDS_PER_BRAM   2    // Two words fill one BRAM

// Phase timing in clock cycles
`define NTT_DECO_LATE        2    // Decode strobe length
`define NTT_EXEC_CYCLES      120  // Execute window length
`define NTT_BU_LATE          7    // Butterfly latency between write-backs

`endif

//--- hdl/ntt_ctrl_pkg.sv
/*
 * NTT controller types.
 * Coefficient, BRAM address and write enable types, the phase
 * encoding, and the input word seen as raw bits or as coefficients.
 */
`default_nettype none

`include "ntt_ctrl_params.svh"

package ntt_ctrl_pkg;

    // One coefficient as stored in a BRAM entry
    typedef logic [`NTT_COEFF_W-1:0]  coeff_t;

    typedef logic [`NTT_ADDR_W-1:0]   bram_addr_t;   // Address inside one BRAM
    typedef logic [`NTT_NUM_BRAM-1:0] bram_we_t;     // One-hot, bit b selects BRAM b

    // Controller phases, in run order
    typedef enum logic [2:0] {
        PH_IDLE   = 3'd0,
        PH_LOAD   = 3'd1,
        PH_DECODE = 3'd2,
        PH_EXEC   = 3'd3,
        PH_DONE   = 3'd4
    } phase_t;

    // Input word, flat or split into coefficients
    // Coefficient 0 sits in the top 12 bits
    typedef union packed {
        logic [`NTT_WORD_W-1:0]                bits;
        coeff_t [0:`NTT_COEFFS_PER_WORD-1]     coeffs;
    } coeff_word_u;

endpackage

`default_nettype wire

//--- hdl/ntt_load_unpacker.sv
/*
 * NTT load unpacker.
 * Splits each accepted input beat into one even/odd coefficient
 * pair, builds the two BRAM addresses and the one-hot write
 * enable, and flags the last beat of the load.
 */
`timescale 1ns/1ps
`default_nettype none

`include "ntt_ctrl_params.svh"

module ntt_load_unpacker (
    input  wire logic                      clk_i,
    input  wire logic                      rst_i,
    input  wire logic                      load_en,      // Phase is load
    input  wire logic                      valid_input,
    input  wire ntt_ctrl_pkg::coeff_word_u din,
    output logic                           load_last,    // Beat writing the final pair
    output ntt_ctrl_pkg::coeff_t           din_load_a,
    output ntt_ctrl_pkg::coeff_t           din_load_b,
    output ntt_ctrl_pkg::bram_addr_t       addr_load_a,
    output ntt_ctrl_pkg::bram_addr_t       addr_load_b,
    output ntt_ctrl_pkg::bram_we_t         we
);

    localparam int PAIR_W = $clog2(`NTT_PAIRS_PER_WORD);
    localparam int WORD_W = ($clog2(`NTT_WORDS_PER_BRAM) > 0) ? $clog2(`NTT_WORDS_PER_BRAM) : 1;
    localparam int BRAM_W = $clog2(`NTT_NUM_BRAM);

    localparam logic [PAIR_W-1:0] PAIR_LAST = PAIR_W'(`NTT_PAIRS_PER_WORD - 1);
    localparam logic [WORD_W-1:0] WORD_LAST = WORD_W'(`NTT_WORDS_PER_BRAM - 1);
    localparam logic [BRAM_W-1:0] BRAM_LAST = BRAM_W'(`NTT_NUM_BRAM - 1);

    logic [PAIR_W-1:0] pair_cnt;   // Pair within the current word
    logic [WORD_W-1:0] word_cnt;   // Word within the current BRAM
    logic [BRAM_W-1:0] bram_cnt;   // BRAM being filled
    logic              accept;

    // Only the load phase takes beats and nothing stalls the source
    assign accept = load_en & valid_input;

    assign load_last = accept
                     & (pair_cnt == PAIR_LAST)
                     & (word_cnt == WORD_LAST)
                     & (bram_cnt == BRAM_LAST);

    // Pair, word and BRAM counters nest like an odometer
    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            pair_cnt <= '0;
            word_cnt <= '0;
            bram_cnt <= '0;
        end else if (accept) begin
            if (pair_cnt == PAIR_LAST) begin
                pair_cnt <= '0;
                if (word_cnt == WORD_LAST) begin
                    word_cnt <= '0;
                    // Wraps to zero after BRAM 7 for the next run
                    bram_cnt <= bram_cnt + 1'b1;
                end else begin
                    word_cnt <= word_cnt + 1'b1;
                end
            end else begin
                pair_cnt <= pair_cnt + 1'b1;
            end
        end
    end

    // Write port registers, one cycle behind the accepting edge
    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            din_load_a  <= '0;
            din_load_b  <= '0;
            addr_load_a <= '0;
            addr_load_b <= '0;
            we          <= '0;
        end else if (accept) begin
            din_load_a  <= din.coeffs[{pair_cnt, 1'b0}];   // Coefficient 2p
            din_load_b  <= din.coeffs[{pair_cnt, 1'b1}];   // Coefficient 2p+1
            // Address is w*16 + 2p on port A, next entry on port B
            addr_load_a <= ntt_ctrl_pkg::bram_addr_t'({word_cnt, pair_cnt, 1'b0});
            addr_load_b <= ntt_ctrl_pkg::bram_addr_t'({word_cnt, pair_cnt, 1'b1});
            we          <= ntt_ctrl_pkg::bram_we_t'(1) << bram_cnt;
        end else begin
            we          <= '0;   // Data and addresses keep their last value
        end
    end

    // At most one BRAM written per cycle
    a_we_onehot0 : assert property (@(posedge clk_i) disable iff (rst_i)
        $onehot0(we))
        else $error("we is not zero or one-hot");

    // A gap on the input leaves the ports quiet next cycle
    a_we_idle : assert property (@(posedge clk_i) disable iff (rst_i)
        !accept |=> (we == '0))
        else $error("we set without an accepted beat");

endmodule

`default_nettype wire

//--- hdl/ntt_phase_sequencer.sv
/*
 * NTT phase sequencer.
 * Steps idle, load, decode, execute and done. Latches the mode at
 * start and shows it per phase, times the decode strobe and the
 * execute window, and pulses write-back once per butterfly latency.
 */
`timescale 1ns/1ps
`default_nettype none

`include "ntt_ctrl_params.svh"

module ntt_phase_sequencer (
    input  wire logic clk_i,
    input  wire logic rst_i,
    input  wire logic start,          // One-cycle request, honoured in idle only
    input  wire logic ntt_mode,       // 1 for NTT, 0 for inverse
    input  wire logic load_last,      // From the unpacker
    output logic      load_en,
    output logic      is_ntt_load,
    output logic      start_decode,
    output logic      is_ntt_decode,
    output logic      start_bram_exec,
    output logic      is_ntt_exec,
    output logic      start_bram_write,
    output logic      done_all
);

    localparam int DECO_CNT_W = $clog2(`NTT_DECO_LATE + 1);
    localparam int EXEC_CNT_W = $clog2(`NTT_EXEC_CYCLES + 1);
    localparam int BU_CNT_W   = $clog2(`NTT_BU_LATE + 1);

    localparam logic [DECO_CNT_W-1:0] DECO_LAST = DECO_CNT_W'(`NTT_DECO_LATE - 1);
    localparam logic [EXEC_CNT_W-1:0] EXEC_LAST = EXEC_CNT_W'(`NTT_EXEC_CYCLES - 1);
    localparam logic [BU_CNT_W-1:0]   BU_LAST   = BU_CNT_W'(`NTT_BU_LATE - 1);
    // Pulse is registered, so it is armed one count early
    localparam logic [BU_CNT_W-1:0]   BU_ARM    = BU_CNT_W'(`NTT_BU_LATE - 2);

    ntt_ctrl_pkg::phase_t  phase;
    logic                  mode_q;      // Mode captured at start
    logic [DECO_CNT_W-1:0] deco_cnt;
    logic [EXEC_CNT_W-1:0] exec_cnt;    // Execute cycle index
    logic [BU_CNT_W-1:0]   bu_cnt;      // Execute index modulo butterfly latency

    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            phase            <= ntt_ctrl_pkg::PH_IDLE;
            mode_q           <= 1'b0;
            deco_cnt         <= '0;
            exec_cnt         <= '0;
            bu_cnt           <= '0;
            load_en          <= 1'b0;
            is_ntt_load      <= 1'b0;
            start_decode     <= 1'b0;
            is_ntt_decode    <= 1'b0;
            start_bram_exec  <= 1'b0;
            is_ntt_exec      <= 1'b0;
            start_bram_write <= 1'b0;
            done_all         <= 1'b0;
        end else begin
            case (phase)
                ntt_ctrl_pkg::PH_IDLE: begin
                    if (start) begin
                        phase       <= ntt_ctrl_pkg::PH_LOAD;
                        mode_q      <= ntt_mode;
                        load_en     <= 1'b1;
                        is_ntt_load <= ntt_mode;
                    end
                end

                ntt_ctrl_pkg::PH_LOAD: begin
                    // Unpacker owns acceptance, only its last beat matters here
                    if (load_last) begin
                        phase         <= ntt_ctrl_pkg::PH_DECODE;
                        load_en       <= 1'b0;
                        is_ntt_load   <= 1'b0;
                        start_decode  <= 1'b1;
                        is_ntt_decode <= mode_q;
                        deco_cnt      <= '0;
                    end
                end

                ntt_ctrl_pkg::PH_DECODE: begin
                    if (deco_cnt == DECO_LAST) begin
                        phase           <= ntt_ctrl_pkg::PH_EXEC;
                        start_decode    <= 1'b0;
                        is_ntt_decode   <= 1'b0;
                        start_bram_exec <= 1'b1;
                        is_ntt_exec     <= mode_q;
                        exec_cnt        <= '0;
                        bu_cnt          <= '0;
                    end else begin
                        deco_cnt <= deco_cnt + 1'b1;
                    end
                end

                ntt_ctrl_pkg::PH_EXEC: begin
                    if (exec_cnt == EXEC_LAST) begin
                        phase            <= ntt_ctrl_pkg::PH_DONE;
                        start_bram_exec  <= 1'b0;
                        is_ntt_exec      <= 1'b0;
                        start_bram_write <= 1'b0;
                        done_all         <= 1'b1;
                    end else begin
                        exec_cnt         <= exec_cnt + 1'b1;
                        bu_cnt           <= (bu_cnt == BU_LAST) ? '0 : bu_cnt + 1'b1;
                        // High in the cycle whose index mod 7 is 6
                        start_bram_write <= (bu_cnt == BU_ARM);
                    end
                end

                ntt_ctrl_pkg::PH_DONE: begin
                    done_all <= 1'b0;   // Single-cycle pulse
                    phase    <= ntt_ctrl_pkg::PH_IDLE;
                end

                default: phase <= ntt_ctrl_pkg::PH_IDLE;
            endcase
        end
    end

    // Done never stretches into a second cycle
    a_done_single : assert property (@(posedge clk_i) disable iff (rst_i)
        done_all |=> !done_all)
        else $error("done_all high on two cycles in a row");

    // Write-back pulses stay inside the execute window
    a_write_in_exec : assert property (@(posedge clk_i) disable iff (rst_i)
        start_bram_write |-> start_bram_exec)
        else $error("start_bram_write outside the execute window");

endmodule

`default_nettype wire

//--- hdl/ntt_ctrl_top.sv
/*
 * NTT controller top.
 * Joins the load unpacker and the phase sequencer. The sequencer's
 * load enable doubles as the external busy flag.
 */
`timescale 1ns/1ps
`default_nettype none

module ntt_ctrl_top (
    input  wire logic                      clk_i,
    input  wire logic                      rst_i,
    input  wire logic                      start,
    input  wire logic                      ntt_mode,
    input  wire logic                      valid_input,
    input  wire ntt_ctrl_pkg::coeff_word_u din,
    // BRAM write ports
    output ntt_ctrl_pkg::coeff_t           din_load_a,
    output ntt_ctrl_pkg::coeff_t           din_load_b,
    output ntt_ctrl_pkg::bram_addr_t       addr_load_a,
    output ntt_ctrl_pkg::bram_addr_t       addr_load_b,
    output ntt_ctrl_pkg::bram_we_t         we,
    // Phase strobes and mode copies
    output logic                           load_busy,
    output logic                           is_ntt_load,
    output logic                           start_decode,
    output logic                           is_ntt_decode,
    output logic                           start_bram_exec,
    output logic                           is_ntt_exec,
    output logic                           start_bram_write,
    output logic                           done_all
);

    logic load_en;     // High for the whole load phase
    logic load_last;   // Final pair of BRAM 7 accepted

    assign load_busy = load_en;

    // Coefficient pairs into the eight BRAMs
    ntt_load_unpacker ntt_load_unpacker_inst (
        .clk_i       (clk_i),
        .rst_i       (rst_i),
        .load_en     (load_en),
        .valid_input (valid_input),
        .din         (din),
        .load_last   (load_last),
        .din_load_a  (din_load_a),
        .din_load_b  (din_load_b),
        .addr_load_a (addr_load_a),
        .addr_load_b (addr_load_b),
        .we          (we)
    );

    // Run control from start to done
    ntt_phase_sequencer ntt_phase_sequencer_inst (
        .clk_i            (clk_i),
        .rst_i            (rst_i),
        .start            (start),
        .ntt_mode         (ntt_mode),
        .load_last        (load_last),
        .load_en          (load_en),
        .is_ntt_load      (is_ntt_load),
        .start_decode     (start_decode),
        .is_ntt_decode    (is_ntt_decode),
        .start_bram_exec  (start_bram_exec),
        .is_ntt_exec      (is_ntt_exec),
        .start_bram_write (start_bram_write),
        .done_all         (done_all)
    );

endmodule

`default_nettype wire

//--- test/ntt_ctrl_tb.sv
/*
 * NTT controller testbench.
 * Runs three back-to-back transforms with random input words and
 * random valid gaps. A cycle model of the phases and a reference
 * for the BRAM write mapping are compared with the DUT every cycle.
 */
`timescale 1ns/1ps
`default_nettype none

`include "ntt_ctrl_params.svh"

module ntt_ctrl_tb;

    localparam int NUM_RUNS       = 3;
    localparam int TIMEOUT_CYCLES = 2000;   // Three runs of up to ~420 cycles with margin
    localparam int LOAD_BEATS     = `NTT_NUM_BRAM * `NTT_WORDS_PER_BRAM * `NTT_PAIRS_PER_WORD;
    localparam int WB_PULSES      = `NTT_EXEC_CYCLES / `NTT_BU_LATE;   // 17 write-backs

    // Expected contents of the write ports for one accepted beat
    typedef struct packed {
        ntt_ctrl_pkg::coeff_t     data_a;
        ntt_ctrl_pkg::coeff_t     data_b;
        ntt_ctrl_pkg::bram_addr_t addr_a;
        ntt_ctrl_pkg::bram_addr_t addr_b;
        ntt_ctrl_pkg::bram_we_t   we;
    } wr_exp_t;

    logic                      clk_i;
    logic                      rst_i;
    logic                      start;
    logic                      ntt_mode;
    logic                      valid_input;
    ntt_ctrl_pkg::coeff_word_u din;
    ntt_ctrl_pkg::coeff_t      din_load_a;
    ntt_ctrl_pkg::coeff_t      din_load_b;
    ntt_ctrl_pkg::bram_addr_t  addr_load_a;
    ntt_ctrl_pkg::bram_addr_t  addr_load_b;
    ntt_ctrl_pkg::bram_we_t    we;
    logic                      load_busy;
    logic                      is_ntt_load;
    logic                      start_decode;
    logic                      is_ntt_decode;
    logic                      start_bram_exec;
    logic                      is_ntt_exec;
    logic                      start_bram_write;
    logic                      done_all;

    // Phase model state after the most recent rising edge
    ntt_ctrl_pkg::phase_t m_phase = ntt_ctrl_pkg::PH_IDLE;
    logic    m_mode        = 1'b0;
    int      m_cnt         = 0;      // Decode or execute cycle index
    int      m_beats       = 0;
    int      m_pair        = 0;
    int      m_word        = 0;
    int      m_bram        = 0;
    wr_exp_t wr_queue[$];            // Accepted beats waiting for their write
    logic    ports_written = 1'b0;   // Data and address ports left zero so far
    int      wr_pulses     = 0;
    int      exec_seen     = 0;
    int      runs_done     = 0;
    int      cycle_cnt     = 0;
    logic [31:0] lcg_state = 32'hb1a4_790e;

    ntt_ctrl_top ntt_ctrl_top_inst (
        .clk_i            (clk_i),
        .rst_i            (rst_i),
        .start            (start),
        .ntt_mode         (ntt_mode),
        .valid_input      (valid_input),
        .din              (din),
        .din_load_a       (din_load_a),
        .din_load_b       (din_load_b),
        .addr_load_a      (addr_load_a),
        .addr_load_b      (addr_load_b),
        .we               (we),
        .load_busy        (load_busy),
        .is_ntt_load      (is_ntt_load),
        .start_decode     (start_decode),
        .is_ntt_decode    (is_ntt_decode),
        .start_bram_exec  (start_bram_exec),
        .is_ntt_exec      (is_ntt_exec),
        .start_bram_write (start_bram_write),
        .done_all         (done_all)
    );

    initial begin
        clk_i = 1'b0;
        forever #20 clk_i = ~clk_i;   // 40 ns period
    end

    // Numerical Recipes constants
    function logic [31:0] lcg_next();
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
        return lcg_state;
    endfunction

    // Pair p of a word goes to entries w*16+2p and w*16+2p+1 of BRAM b
    function automatic wr_exp_t ref_write(input int b, input int w, input int p,
                                          input logic [`NTT_WORD_W-1:0] word);
        wr_exp_t e;
        e.data_a = word[`NTT_WORD_W-1-(2*p)*`NTT_COEFF_W -: `NTT_COEFF_W];   // Coeff 0 on top
        e.data_b = word[`NTT_WORD_W-1-(2*p+1)*`NTT_COEFF_W -: `NTT_COEFF_W];
        e.addr_a = ntt_ctrl_pkg::bram_addr_t'(w * 16 + 2 * p);
        e.addr_b = ntt_ctrl_pkg::bram_addr_t'(w * 16 + 2 * p + 1);
        e.we     = ntt_ctrl_pkg::bram_we_t'(1) << b;
        return e;
    endfunction

    task automatic compare_value(input string name, input logic [31:0] expected,
                                 input logic [31:0] actual);
        if (actual !== expected) begin
            $display("FAILED at %0d ns: %s expected 0x%0h, got 0x%0h",
                     $time, name, expected, actual);
            $display("TEST RESULT: FAIL");
            $fatal(1, "value mismatch");
        end
    endtask

    // Compare every output with the model for the current cycle
    task automatic check_outputs();
        wr_exp_t e;
        logic    in_load;
        logic    in_deco;
        logic    in_exec;
        in_load = (m_phase == ntt_ctrl_pkg::PH_LOAD);
        in_deco = (m_phase == ntt_ctrl_pkg::PH_DECODE);
        in_exec = (m_phase == ntt_ctrl_pkg::PH_EXEC);
        compare_value("load_busy", 32'(in_load), 32'(load_busy));
        compare_value("is_ntt_load", 32'(in_load & m_mode), 32'(is_ntt_load));
        compare_value("start_decode", 32'(in_deco), 32'(start_decode));
        compare_value("is_ntt_decode", 32'(in_deco & m_mode), 32'(is_ntt_decode));
        compare_value("start_bram_exec", 32'(in_exec), 32'(start_bram_exec));
        compare_value("is_ntt_exec", 32'(in_exec & m_mode), 32'(is_ntt_exec));
        compare_value("start_bram_write",
                      32'(in_exec && (m_cnt % `NTT_BU_LATE == `NTT_BU_LATE - 1)),
                      32'(start_bram_write));
        compare_value("done_all", 32'(m_phase == ntt_ctrl_pkg::PH_DONE), 32'(done_all));
        if (wr_queue.size() > 0) begin
            e = wr_queue.pop_front();
            compare_value("din_load_a", 32'(e.data_a), 32'(din_load_a));
            compare_value("din_load_b", 32'(e.data_b), 32'(din_load_b));
            compare_value("addr_load_a", 32'(e.addr_a), 32'(addr_load_a));
            compare_value("addr_load_b", 32'(e.addr_b), 32'(addr_load_b));
            compare_value("we", 32'(e.we), 32'(we));
        end else begin
            compare_value("we", 32'd0, 32'(we));   // Quiet after a gap
            if (!ports_written) begin
                compare_value("din_load_a", 32'd0, 32'(din_load_a));
                compare_value("din_load_b", 32'd0, 32'(din_load_b));
                compare_value("addr_load_a", 32'd0, 32'(addr_load_a));
                compare_value("addr_load_b", 32'd0, 32'(addr_load_b));
            end
        end
        if (start_bram_write) wr_pulses++;
        if (start_bram_exec) exec_seen++;
        if (done_all) begin
            compare_value("write-back pulses in run", WB_PULSES, wr_pulses);
            compare_value("execute cycles in run", `NTT_EXEC_CYCLES, exec_seen);
            runs_done++;
            wr_pulses = 0;
            exec_seen = 0;
        end
    endtask

    // Move the model across the coming rising edge
    task automatic step_model();
        if (rst_i) begin
            m_phase       = ntt_ctrl_pkg::PH_IDLE;
            m_mode        = 1'b0;
            m_beats       = 0;
            m_pair        = 0;
            m_word        = 0;
            m_bram        = 0;
            ports_written = 1'b0;
            wr_queue.delete();
        end else begin
            case (m_phase)
                ntt_ctrl_pkg::PH_IDLE: begin
                    if (start) begin
                        m_phase = ntt_ctrl_pkg::PH_LOAD;
                        m_mode  = ntt_mode;   // Latched here only
                    end
                end
                ntt_ctrl_pkg::PH_LOAD: begin
                    if (valid_input) begin
                        wr_queue.push_back(ref_write(m_bram, m_word, m_pair, din.bits));
                        ports_written = 1'b1;
                        m_beats++;
                        m_pair = (m_pair + 1) % `NTT_PAIRS_PER_WORD;
                        if (m_pair == 0) m_word = (m_word + 1) % `NTT_WORDS_PER_BRAM;
                        if (m_pair == 0 && m_word == 0) m_bram = (m_bram + 1) % `NTT_NUM_BRAM;
                        if (m_beats == LOAD_BEATS) begin
                            m_phase = ntt_ctrl_pkg::PH_DECODE;
                            m_cnt   = 0;
                            m_beats = 0;
                        end
                    end
                end
                ntt_ctrl_pkg::PH_DECODE: begin
                    m_cnt++;
                    if (m_cnt == `NTT_DECO_LATE) begin
                        m_phase = ntt_ctrl_pkg::PH_EXEC;
                        m_cnt   = 0;
                    end
                end
                ntt_ctrl_pkg::PH_EXEC: begin
                    m_cnt++;
                    if (m_cnt == `NTT_EXEC_CYCLES) m_phase = ntt_ctrl_pkg::PH_DONE;
                end
                default: m_phase = ntt_ctrl_pkg::PH_IDLE;   // Done lasts one cycle
            endcase
        end
    endtask

    // Outputs are stable at the falling edge
    initial begin : compare_proc
        @(posedge clk_i);
        forever begin
            @(negedge clk_i);
            check_outputs();
            step_model();
        end
    end

    // One full transform entered and left 1 ns after a rising edge
    task automatic run_transform(input logic mode);
        logic [31:0] r;
        int          n;
        start    = 1'b1;
        ntt_mode = mode;
        @(posedge clk_i);
        #1;
        start    = 1'b0;
        ntt_mode = ~mode;   // Must not leak into the latched mode
        for (int w = 0; w < `NTT_NUM_BRAM * `NTT_WORDS_PER_BRAM; w++) begin
            for (int i = 0; i < `NTT_WORD_W / 32; i++) din.bits[i*32 +: 32] = lcg_next();
            n = 0;
            while (n < `NTT_PAIRS_PER_WORD) begin
                r           = lcg_next();
                valid_input = (r[31:30] != 2'b00);   // About a quarter idle
                start       = (w == 5 && n == 3);    // Stray start during load
                @(posedge clk_i);
                #1;
                if (valid_input) n++;
            end
        end
        valid_input = 1'b0;
        start       = 1'b0;
        while (done_all !== 1'b1) @(negedge clk_i);
        @(posedge clk_i);   // Leaves done, idle from here
        #1;
    endtask

    initial begin
        rst_i       = 1'b1;
        start       = 1'b0;
        ntt_mode    = 1'b0;
        valid_input = 1'b0;
        din         = '0;
        repeat (2) @(posedge clk_i);
        #1;
        rst_i = 1'b0;
        run_transform(1'b1);
        run_transform(1'b0);
        run_transform(1'b1);
        repeat (4) @(posedge clk_i);
        #1;
        if (runs_done != NUM_RUNS) begin
            $display("Only %0d of %0d runs reached done", runs_done, NUM_RUNS);
            $display("TEST RESULT: FAIL");
            $fatal(1, "missing runs");
        end else begin
            $display("TEST RESULT: PASS");
            $finish;
        end
    end

    always @(posedge clk_i) begin
        cycle_cnt <= cycle_cnt + 1;
        if (cycle_cnt == TIMEOUT_CYCLES) begin
            $display("Timeout: the runs did not finish within %0d cycles", TIMEOUT_CYCLES);
            $display("TEST RESULT: FAIL");
            $fatal(1, "simulation timeout");
        end
    end

endmodule

`default_nettype wire

//--- sim.f
+incdir+hdl
hdl/ntt_ctrl_pkg.sv
hdl/ntt_load_unpacker.sv
hdl/ntt_phase_sequencer.sv
hdl/ntt_ctrl_top.sv
test/ntt_ctrl_tb.sv

//--- run_sim.sh
#!/bin/sh
# Build and run the NTT controller testbench with Verilator.
# Exit status is nonzero when the build or the simulation fails.
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -sv -f sim.f --top-module ntt_ctrl_tb -Mdir obj_dir \
    && ./obj_dir/Vntt_ctrl_tb \
    || { echo "Simulation failed"; exit 1; }
